// File: hw/mips_pkg.sv
`default_nettype none

package mips_pkg;

  // ---------------------------------------------------------------------
  // widths
  // ---------------------------------------------------------------------
  localparam int xlen       = 32;  // data and address width
  localparam int reg_addr_w = 5;   // register index

  // ---------------------------------------------------------------------
  // instruction encodings
  // ---------------------------------------------------------------------
  typedef enum logic [5:0] {
    op_rtype = 6'h00,
    op_beq   = 6'h04,
    op_bne   = 6'h05,
    op_addi  = 6'h08,
    op_addiu = 6'h09,
    op_ori   = 6'h0d,
    op_lui   = 6'h0f,
    op_lw    = 6'h23,
    op_sw    = 6'h2b
  } opcode_e;

  typedef enum logic [5:0] {
    f_add  = 6'h20,
    f_addu = 6'h21,
    f_sub  = 6'h22,
    f_subu = 6'h23,
    f_and  = 6'h24,
    f_or   = 6'h25,
    f_slt  = 6'h2a
  } funct_e;

  typedef enum logic [2:0] {
    alu_and = 3'b000,
    alu_or  = 3'b001,
    alu_add = 3'b010,
    alu_sub = 3'b110,
    alu_slt = 3'b111
  } alu_op_e;

  typedef enum logic [1:0] {
    fwd_none = 2'b00,  // register file value
    fwd_wb   = 2'b01,
    fwd_mem  = 2'b10
  } fwd_sel_e;

  // decoded control, 12 bits
  typedef struct packed {
    logic    regwrite;
    logic    regdst;
    logic    alusrc;
    logic    memwrite;
    logic    memtoreg;
    logic    branch;
    logic    branch_ne;  // bne, inverts the zero test
    logic    signext;
    logic    shiftl16;
    alu_op_e alu_op;
  } ctrl_t;

  // ---------------------------------------------------------------------
  // stage registers
  // ---------------------------------------------------------------------
  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] instr;
    logic [xlen-1:0] pc_plus4;
  } if_id_t;

  typedef struct packed {
    ctrl_t                 ctrl;
    logic [xlen-1:0]       pc_plus4;
    logic [xlen-1:0]       rd1;
    logic [xlen-1:0]       rd2;
    logic [xlen-1:0]       imm;  // already extended or shifted
    logic [reg_addr_w-1:0] rs;
    logic [reg_addr_w-1:0] rt;
    logic [reg_addr_w-1:0] rd;
  } id_ex_t;

  typedef struct packed {
    logic                  regwrite;
    logic                  memtoreg;
    logic                  memwrite;
    logic                  branch;
    logic                  branch_ne;
    logic [xlen-1:0]       target;
    logic [xlen-1:0]       alu_result;
    logic                  zero;
    logic [xlen-1:0]       store_data;
    logic [reg_addr_w-1:0] dst;
  } ex_mem_t;

  typedef struct packed {
    logic                  regwrite;
    logic                  memtoreg;
    logic [xlen-1:0]       alu_result;
    logic [xlen-1:0]       read_data;
    logic [reg_addr_w-1:0] dst;
  } mem_wb_t;

endpackage

`default_nettype wire

// File: hw/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
  input  logic [mips_pkg::xlen-1:0] a,
  input  logic [mips_pkg::xlen-1:0] b,
  input  mips_pkg::alu_op_e         op,
  output logic [mips_pkg::xlen-1:0] result,
  output logic                      zero
);
  import mips_pkg::*;

  logic less;

  assign less = ($signed(a) < $signed(b));  // slt and sltu both signed here

  always_comb
  begin
    case (op)
      alu_and: result = a & b;
      alu_or:  result = a | b;
      alu_add: result = a + b;
      alu_sub: result = a - b;
      alu_slt: result = {{(xlen-1){1'b0}}, less};
      default: result = '0;
    endcase
  end

  assign zero = (result == '0);  // branch compare

endmodule

`default_nettype wire

// File: hw/register_file.sv
`timescale 1ns/100ps
`default_nettype none

module register_file (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            we,
  input  logic [mips_pkg::reg_addr_w-1:0] ra1,
  input  logic [mips_pkg::reg_addr_w-1:0] ra2,
  input  logic [mips_pkg::reg_addr_w-1:0] wa,
  input  logic [mips_pkg::xlen-1:0]       wd,
  output logic [mips_pkg::xlen-1:0]       rd1,
  output logic [mips_pkg::xlen-1:0]       rd2
);
  import mips_pkg::*;

  logic [xlen-1:0] regs [1:31];  // r0 is not stored

  always_ff @(posedge clk)
  begin
    if (reset)
      regs <= '{default: '0};  // architectural state starts at zero
    else if (we && (wa != '0))
      regs[wa] <= wd;
  end

  // write-through so WB and ID can share a cycle
  assign rd1 = (ra1 == '0) ? '0 : (we && (wa == ra1)) ? wd : regs[ra1];
  assign rd2 = (ra2 == '0) ? '0 : (we && (wa == ra2)) ? wd : regs[ra2];

  r0_reads_zero: assert property (@(posedge clk) disable iff (reset)
    ((ra1 == '0) |-> (rd1 == '0)) and ((ra2 == '0) |-> (rd2 == '0)))
    else $error("register 0 read back nonzero");

endmodule

`default_nettype wire

// File: hw/hazard_unit.sv
`timescale 1ns/100ps
`default_nettype none

module hazard_unit (
  input  logic [mips_pkg::reg_addr_w-1:0] ex_rs,
  input  logic [mips_pkg::reg_addr_w-1:0] ex_rt,
  input  logic [mips_pkg::reg_addr_w-1:0] mem_dst,
  input  logic [mips_pkg::reg_addr_w-1:0] wb_dst,
  input  logic [mips_pkg::reg_addr_w-1:0] id_rs,
  input  logic [mips_pkg::reg_addr_w-1:0] id_rt,
  input  logic                            mem_regwrite,
  input  logic                            wb_regwrite,
  input  logic                            ex_memtoreg,
  output mips_pkg::fwd_sel_e              fwd_a,
  output mips_pkg::fwd_sel_e              fwd_b,
  output logic                            stall
);
  import mips_pkg::*;

  // younger result wins, r0 never forwarded
  function automatic fwd_sel_e fwd_select(
    input logic [reg_addr_w-1:0] src,
    input logic                  m_we,
    input logic [reg_addr_w-1:0] m_dst,
    input logic                  w_we,
    input logic [reg_addr_w-1:0] w_dst
  );
    if (m_we && (m_dst != '0) && (m_dst == src))
      return fwd_mem;
    else if (w_we && (w_dst != '0) && (w_dst == src))
      return fwd_wb;
    else
      return fwd_none;
  endfunction

  assign fwd_a = fwd_select(ex_rs, mem_regwrite, mem_dst, wb_regwrite, wb_dst);
  assign fwd_b = fwd_select(ex_rt, mem_regwrite, mem_dst, wb_regwrite, wb_dst);

  // load in EX writes rt, its data is only ready after MEM
  assign stall = ex_memtoreg && ((ex_rt == id_rs) || (ex_rt == id_rt));

  stall_only_on_load: assert final (!stall || ex_memtoreg)
    else $error("stall raised without a load in EX");

endmodule

`default_nettype wire

// File: hw/control_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module control_decoder (
  input  mips_pkg::opcode_e opcode,
  input  mips_pkg::funct_e  funct,
  output mips_pkg::ctrl_t   ctrl
);
  import mips_pkg::*;

  // main and alu decode in one pass, alu_op comes out in ID
  always_comb
  begin
    ctrl = '0;  // unknown opcode acts as nop
    case (opcode)
      op_rtype:
      begin
        ctrl.regwrite = 1'b1;
        ctrl.regdst   = 1'b1;
        case (funct)
          f_add, f_addu: ctrl.alu_op = alu_add;  // overflow not trapped
          f_sub, f_subu: ctrl.alu_op = alu_sub;
          f_and:         ctrl.alu_op = alu_and;
          f_or:          ctrl.alu_op = alu_or;
          f_slt:         ctrl.alu_op = alu_slt;
          default:       ctrl        = '0;       // includes sll nop
        endcase
      end
      op_lw:
      begin
        ctrl.regwrite = 1'b1;
        ctrl.alusrc   = 1'b1;
        ctrl.memtoreg = 1'b1;
        ctrl.signext  = 1'b1;
        ctrl.alu_op   = alu_add;
      end
      op_sw:
      begin
        ctrl.alusrc   = 1'b1;
        ctrl.memwrite = 1'b1;
        ctrl.signext  = 1'b1;
        ctrl.alu_op   = alu_add;
      end
      op_beq, op_bne:
      begin
        ctrl.branch    = 1'b1;
        ctrl.branch_ne = (opcode == op_bne);
        ctrl.signext   = 1'b1;
        ctrl.alu_op    = alu_sub;  // zero flag carries the compare
      end
      op_addi, op_addiu:
      begin
        ctrl.regwrite = 1'b1;
        ctrl.alusrc   = 1'b1;
        ctrl.signext  = 1'b1;
        ctrl.alu_op   = alu_add;
      end
      op_ori:
      begin
        ctrl.regwrite = 1'b1;
        ctrl.alusrc   = 1'b1;
        ctrl.alu_op   = alu_or;  // zero extended immediate
      end
      op_lui:
      begin
        ctrl.regwrite = 1'b1;
        ctrl.alusrc   = 1'b1;
        ctrl.shiftl16 = 1'b1;
        ctrl.alu_op   = alu_add;  // rs field is zero
      end
      default: ctrl = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: hw/mips_pipeline.sv
`timescale 1ns/100ps
`default_nettype none

module mips_pipeline #(
  parameter logic [mips_pkg::xlen-1:0] reset_pc = '0
) (
  input  logic                      clk,
  input  logic                      reset,
  output logic [mips_pkg::xlen-1:0] pc,
  input  logic [mips_pkg::xlen-1:0] instr,
  output logic                      memwrite,
  output logic [mips_pkg::xlen-1:0] memaddr,
  output logic [mips_pkg::xlen-1:0] memwritedata,
  input  logic [mips_pkg::xlen-1:0] memreaddata
);
  import mips_pkg::*;

  if_id_t          if_id;
  id_ex_t          id_ex, id_ex_d;
  ex_mem_t         ex_mem, ex_mem_d;
  mem_wb_t         mem_wb, mem_wb_d;
  ctrl_t           dec_ctrl, id_ctrl;
  fwd_sel_e        fwd_a, fwd_b;
  logic [xlen-1:0] pc_plus4, id_rd1, id_rd2, id_imm;
  logic [xlen-1:0] src_a, src_b_reg, src_b, alu_result, wb_result;
  logic [15:0]     imm16;
  logic            alu_zero, stall, pcsrc;

  function automatic logic [xlen-1:0] fwd_mux(
    input fwd_sel_e        sel,
    input logic [xlen-1:0] reg_val,
    input logic [xlen-1:0] mem_val,
    input logic [xlen-1:0] wb_val
  );
    case (sel)
      fwd_mem: return mem_val;
      fwd_wb:  return wb_val;
      default: return reg_val;
    endcase
  endfunction

  // ---------------------------------------------------------------------
  // IF
  // ---------------------------------------------------------------------
  assign pc_plus4 = pc + xlen'(4);

  always_ff @(posedge clk)
  begin
    if (reset)
      pc <= reset_pc;
    else if (pcsrc)
      pc <= ex_mem.target;  // taken branch beats a stall
    else if (!stall)
      pc <= pc_plus4;
  end

  always_ff @(posedge clk)
  begin
    if (!stall)
    begin
      if_id.valid    <= 1'b1;
      if_id.instr    <= instr;
      if_id.pc_plus4 <= pc_plus4;
    end
    if (reset || pcsrc)
      if_id.valid <= 1'b0;
  end

  // ---------------------------------------------------------------------
  // ID
  // ---------------------------------------------------------------------
  control_decoder u_dec (
    .opcode (opcode_e'(if_id.instr[31:26])),
    .funct  (funct_e'(if_id.instr[5:0])),
    .ctrl   (dec_ctrl)
  );

  assign id_ctrl = if_id.valid ? dec_ctrl : '0;
  assign imm16   = if_id.instr[15:0];

  always_comb
  begin
    if (id_ctrl.shiftl16)
      id_imm = {imm16, {(xlen-16){1'b0}}};  // lui
    else if (id_ctrl.signext)
      id_imm = {{(xlen-16){imm16[15]}}, imm16};
    else
      id_imm = {{(xlen-16){1'b0}}, imm16};
  end

  register_file u_rf (
    .clk   (clk),
    .reset (reset),
    .we    (mem_wb.regwrite),
    .ra1   (if_id.instr[25:21]),
    .ra2   (if_id.instr[20:16]),
    .wa    (mem_wb.dst),
    .wd    (wb_result),
    .rd1   (id_rd1),
    .rd2   (id_rd2)
  );

  hazard_unit u_hz (
    .ex_rs        (id_ex.rs),
    .ex_rt        (id_ex.rt),
    .mem_dst      (ex_mem.dst),
    .wb_dst       (mem_wb.dst),
    .id_rs        (if_id.instr[25:21]),
    .id_rt        (if_id.instr[20:16]),
    .mem_regwrite (ex_mem.regwrite),
    .wb_regwrite  (mem_wb.regwrite),
    .ex_memtoreg  (id_ex.ctrl.memtoreg),
    .fwd_a        (fwd_a),
    .fwd_b        (fwd_b),
    .stall        (stall)
  );

  assign id_ex_d = '{ctrl: id_ctrl, pc_plus4: if_id.pc_plus4, rd1: id_rd1, rd2: id_rd2,
                     imm: id_imm, rs: if_id.instr[25:21], rt: if_id.instr[20:16],
                     rd: if_id.instr[15:11]};

  always_ff @(posedge clk)
  begin
    id_ex <= id_ex_d;
    if (reset || pcsrc || stall)
      id_ex.ctrl <= '0;  // bubble
  end

  // ---------------------------------------------------------------------
  // EX
  // ---------------------------------------------------------------------
  assign src_a     = fwd_mux(fwd_a, id_ex.rd1, ex_mem.alu_result, wb_result);
  assign src_b_reg = fwd_mux(fwd_b, id_ex.rd2, ex_mem.alu_result, wb_result);
  assign src_b     = id_ex.ctrl.alusrc ? id_ex.imm : src_b_reg;

  alu u_alu (
    .a      (src_a),
    .b      (src_b),
    .op     (id_ex.ctrl.alu_op),
    .result (alu_result),
    .zero   (alu_zero)
  );

  always_comb
  begin
    ex_mem_d.regwrite   = id_ex.ctrl.regwrite;
    ex_mem_d.memtoreg   = id_ex.ctrl.memtoreg;
    ex_mem_d.memwrite   = id_ex.ctrl.memwrite;
    ex_mem_d.branch     = id_ex.ctrl.branch;
    ex_mem_d.branch_ne  = id_ex.ctrl.branch_ne;
    ex_mem_d.target     = id_ex.pc_plus4 + {id_ex.imm[xlen-3:0], 2'b00};
    ex_mem_d.alu_result = alu_result;
    ex_mem_d.zero       = alu_zero;
    ex_mem_d.store_data = src_b_reg;  // forwarded store value
    ex_mem_d.dst        = id_ex.ctrl.regdst ? id_ex.rd : id_ex.rt;
  end

  always_ff @(posedge clk)
  begin
    ex_mem <= ex_mem_d;
    if (reset || pcsrc)
    begin
      ex_mem.regwrite  <= 1'b0;
      ex_mem.memtoreg  <= 1'b0;
      ex_mem.memwrite  <= 1'b0;
      ex_mem.branch    <= 1'b0;
      ex_mem.branch_ne <= 1'b0;
    end
  end

  // ---------------------------------------------------------------------
  // MEM and WB
  // ---------------------------------------------------------------------
  assign pcsrc        = ex_mem.branch && (ex_mem.zero != ex_mem.branch_ne);
  assign memwrite     = ex_mem.memwrite;
  assign memaddr      = ex_mem.alu_result;
  assign memwritedata = ex_mem.store_data;

  assign mem_wb_d = '{regwrite: ex_mem.regwrite, memtoreg: ex_mem.memtoreg,
                      alu_result: ex_mem.alu_result, read_data: memreaddata,
                      dst: ex_mem.dst};

  always_ff @(posedge clk)
  begin
    mem_wb <= mem_wb_d;
    if (reset)
    begin
      mem_wb.regwrite <= 1'b0;
      mem_wb.memtoreg <= 1'b0;
    end
  end

  assign wb_result = mem_wb.memtoreg ? mem_wb.read_data : mem_wb.alu_result;

  // decoder never sets both for one instruction
  store_not_writeback: assert property (@(posedge clk) disable iff (reset)
    !(ex_mem.memwrite && ex_mem.regwrite))
    else $error("memwrite and regwrite both set in MEM");

endmodule

`default_nettype wire

// File: verification/mips_model.svh
`ifndef MIPS_MODEL_SVH
`define MIPS_MODEL_SVH

// ---------------------------------------------------------------------
// program store, reference state and expected stores
// ---------------------------------------------------------------------
logic [31:0] rom [0:255];
logic [31:0] model_regs [0:31];
logic [31:0] model_dmem [0:63];
logic [31:0] exp_addr [$];
logic [31:0] exp_data [$];
logic [31:0] rnd_state = 32'hc7af_e66e;

function automatic logic [31:0] next_rand();
  rnd_state = rnd_state ^ (rnd_state << 13);
  rnd_state = rnd_state ^ (rnd_state >> 17);
  rnd_state = rnd_state ^ (rnd_state << 5);
  return rnd_state;
endfunction

function automatic int rand_below(input int n);
  return int'(next_rand() % 32'(n));
endfunction

function automatic logic [31:0] enc_r(input logic [5:0] funct, input logic [4:0] rs,
                                      input logic [4:0] rt, input logic [4:0] rd);
  return {6'h00, rs, rt, rd, 5'h00, funct};
endfunction

function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                      input logic [4:0] rt, input logic [15:0] imm);
  return {op, rs, rt, imm};
endfunction

// modes 1 and 2 lean on the last result to build dependences
function automatic logic [4:0] pick_src(input int mode, input logic [4:0] last);
  if ((mode == 1 || mode == 2) && rand_below(4) != 0)
    return last;
  if (mode == 4 && rand_below(4) == 0)
    return 5'd0;
  return 5'(1 + rand_below(7));
endfunction

function automatic logic [5:0] pick_funct();
  case (rand_below(7))
    0: return 6'h20;  // add
    1: return 6'h21;  // addu
    2: return 6'h22;  // sub
    3: return 6'h23;  // subu
    4: return 6'h24;  // and
    5: return 6'h25;  // or
    default: return 6'h2a;  // slt
  endcase
endfunction

// body of random instructions, then one sw per register 1..7, then nops
task automatic gen_program(input int mode, input int body_len);
  logic [4:0]  rs;
  logic [4:0]  rt;
  logic [4:0]  dst;
  logic [4:0]  last;
  logic [15:0] imm;
  logic [15:0] offset;
  int          i;
  int          kind;
  int          off;
  last = 5'd1;
  for (i = 0; i < 256; i++)
    rom[i] = 32'h0;
  for (i = 0; i < body_len; i++)
  begin
    case (mode)
      0: kind = rand_below(4);
      1: kind = rand_below(3);
      2: kind = (rand_below(2) == 0) ? 4 : rand_below(6);  // mostly loads
      default: kind = rand_below(7);
    endcase
    rs     = pick_src(mode, last);
    rt     = pick_src(mode, last);
    dst    = (mode == 4 && rand_below(3) == 0) ? 5'd0 : 5'(1 + rand_below(7));
    imm    = 16'(next_rand());
    offset = 16'(((mode == 2) ? rand_below(4) : rand_below(64)) * 4);
    case (kind)
      0: rom[i] = enc_r(pick_funct(), rs, rt, dst);
      1: rom[i] = enc_i((rand_below(2) != 0) ? 6'h08 : 6'h09, rs, dst, imm);
      2: rom[i] = enc_i(6'h0d, rs, dst, imm);
      3: rom[i] = enc_i(6'h0f, 5'd0, dst, imm);  // lui
      4: rom[i] = enc_i(6'h23, 5'd0, dst, offset);
      5: rom[i] = enc_i(6'h2b, 5'd0, rt, offset);
      default:
      begin
        off = 1 + rand_below(4);
        if (i + 1 + off > body_len)
          off = body_len - i - 1;  // never past the final stores
        rom[i] = enc_i((rand_below(2) != 0) ? 6'h04 : 6'h05, rs, rt, 16'(off));
      end
    endcase
    if (kind <= 4)
      last = dst;
  end
  for (i = 1; i < 8; i++)
    rom[body_len + i - 1] = enc_i(6'h2b, 5'd0, 5'(i), 16'(32'h100 + 4 * (i - 1)));
endtask

// instruction-set semantics, no delay slot
task automatic run_model(input int n_instr);
  logic [31:0] w;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] se;
  logic [31:0] addr;
  int          i;
  for (i = 0; i < 32; i++)
    model_regs[i] = 32'h0;
  for (i = 0; i < 64; i++)
    model_dmem[i] = 32'h0;
  exp_addr.delete();
  exp_data.delete();
  i = 0;
  while (i < n_instr)
  begin
    w    = rom[i];
    a    = model_regs[w[25:21]];
    b    = model_regs[w[20:16]];
    se   = {{16{w[15]}}, w[15:0]};
    addr = a + se;
    i    = i + 1;
    case (w[31:26])
      6'h00:
        case (w[5:0])
          6'h20, 6'h21: model_regs[w[15:11]] = a + b;
          6'h22, 6'h23: model_regs[w[15:11]] = a - b;
          6'h24: model_regs[w[15:11]] = a & b;
          6'h25: model_regs[w[15:11]] = a | b;
          6'h2a: model_regs[w[15:11]] = ($signed(a) < $signed(b)) ? 32'h1 : 32'h0;
          default: ;  // nop
        endcase
      6'h08, 6'h09: model_regs[w[20:16]] = a + se;
      6'h0d: model_regs[w[20:16]] = a | {16'h0, w[15:0]};
      6'h0f: model_regs[w[20:16]] = {w[15:0], 16'h0};
      6'h23: model_regs[w[20:16]] = model_dmem[addr[7:2]];
      6'h2b:
      begin
        model_dmem[addr[7:2]] = b;
        exp_addr.push_back(addr);
        exp_data.push_back(b);
      end
      6'h04: if (a == b) i = i + int'($signed(se));
      6'h05: if (a != b) i = i + int'($signed(se));
      default: ;
    endcase
    model_regs[0] = 32'h0;
  end
endtask

`endif

// File: verification/mips_tb.sv
`timescale 1ns/100ps
`default_nettype none

module mips_tb;

  localparam logic [31:0] start_pc      = 32'h0000_0400;  // rom is indexed by pc[9:2]
  localparam int          store_timeout = 200;  // cycles per store
  localparam int          quiet_window  = 20;

  logic        clk;
  logic        reset;
  logic [31:0] pc;
  logic [31:0] instr;
  logic        memwrite;
  logic [31:0] memaddr;
  logic [31:0] memwritedata;
  logic [31:0] memreaddata;
  logic [31:0] ram [0:63];
  int          err_count;
  int          check_count;
  int          tests_run;
  int          tests_failed;

  `include "mips_model.svh"

  // ---------------------------------------------------------------------
  // memories and DUT
  // ---------------------------------------------------------------------
  assign instr       = rom[pc[9:2]];
  assign memreaddata = ram[memaddr[7:2]];  // 0x100 and up alias the low words

  always @(posedge clk)
  begin
    if (memwrite)
      ram[memaddr[7:2]] <= memwritedata;
  end

  mips_pipeline #(.reset_pc(start_pc)) dut (
    .clk          (clk),
    .reset        (reset),
    .pc           (pc),
    .instr        (instr),
    .memwrite     (memwrite),
    .memaddr      (memaddr),
    .memwritedata (memwritedata),
    .memreaddata  (memreaddata)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    err_count++;
    $display("[FAIL] t=%0t %s expected %h got %h", $time, name, expected, actual);
  endtask

  // ---------------------------------------------------------------------
  // reset, then compare the store stream with the model
  // ---------------------------------------------------------------------
  task automatic apply_reset();
    int i;
    @(negedge clk);
    reset = 1'b1;
    repeat (10)
    begin
      @(negedge clk);
      check_count++;
      if (memwrite !== 1'b0)
        report_mismatch("memwrite", 32'h0, {31'h0, memwrite});
    end
    for (i = 0; i < 64; i++)
      ram[i] = 32'h0;  // old program may have written during the first edge
    reset = 1'b0;
    check_count++;
    if (pc !== start_pc)
      report_mismatch("pc", start_pc, pc);
  endtask

  task automatic run_test(input string name, input int mode, input int body_len);
    int errs_at_start;
    int idx;
    int waited;
    bit lost;
    errs_at_start = err_count;
    lost          = 1'b0;
    gen_program(mode, body_len);
    run_model(body_len + 7);
    apply_reset();
    for (idx = 0; idx < exp_addr.size() && !lost; idx++)
    begin
      waited = 0;
      @(negedge clk);
      while (memwrite !== 1'b1 && waited < store_timeout)
      begin
        @(negedge clk);
        waited++;
      end
      if (memwrite !== 1'b1)
      begin
        err_count++;
        lost = 1'b1;
        $display("ERROR: test %s, store %0d of %0d never arrived within %0d cycles",
                 name, idx + 1, exp_addr.size(), store_timeout);
      end
      else
      begin
        check_count++;
        if (memaddr !== exp_addr[idx])
          report_mismatch("memaddr", exp_addr[idx], memaddr);
        check_count++;
        if (memwritedata !== exp_data[idx])
          report_mismatch("memwritedata", exp_data[idx], memwritedata);
      end
    end
    // nothing else may be stored once the model's stores are done
    if (!lost)
    begin
      repeat (quiet_window)
      begin
        @(negedge clk);
        check_count++;
        if (memwrite !== 1'b0)
        begin
          err_count++;
          $display("ERROR: test %s stored to %h after the last expected store",
                   name, memaddr);
        end
      end
    end
    tests_run++;
    if (err_count == errs_at_start)
      $display("test %-9s ok, %0d stores checked", name, exp_addr.size());
    else
    begin
      tests_failed++;
      $display("test %-9s failed, %0d errors", name, err_count - errs_at_start);
    end
  endtask

  // ---------------------------------------------------------------------
  // test sequence
  // ---------------------------------------------------------------------
  initial
  begin
    reset        = 1'b1;
    err_count    = 0;
    check_count  = 0;
    tests_run    = 0;
    tests_failed = 0;
    for (int i = 0; i < 256; i++)
      rom[i] = 32'h0;
    for (int i = 0; i < 64; i++)
      ram[i] = 32'h0;

    run_test("alu_imm", 0, 40);
    run_test("forward", 1, 40);
    run_test("load_use", 2, 40);
    run_test("branch", 3, 40);
    run_test("zero_reg", 4, 40);
    run_test("mixed_a", 5, 60);
    run_test("mixed_b", 5, 60);

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, check_count, err_count);
    if (err_count == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+verification
hw/mips_pkg.sv
hw/alu.sv
hw/register_file.sv
hw/hazard_unit.sv
hw/control_decoder.sv
hw/mips_pipeline.sv
verification/mips_tb.sv
